/* tb.f */
+incdir+hw
hw/cart_pkg.sv
hw/cart_header.sv
hw/mbc_regs.sv
hw/bank_map.sv
hw/cart_ctrl.sv
hw/cart_mapper.sv
sim/wb_mem_model.sv
sim/tb_cart_mapper.sv

/* Bender.yml */
package:
  name: cart_mapper

sources:
  - include_dirs:
      - hw
    files:
      - hw/cart_pkg.sv
      - hw/cart_header.sv
      - hw/mbc_regs.sv
      - hw/bank_map.sv
      - hw/cart_ctrl.sv
      - hw/cart_mapper.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/wb_mem_model.sv
      - sim/tb_cart_mapper.sv

/* sim/tb_cart_mapper.sv */
`include "cart_settings.svh"

module tb_cart_mapper;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 100; // cycles allowed per wait

	logic                    clk_sys;
	logic                    reset;
	logic                    dl_active;
	logic                    dl_wr;
	logic                    dl_wait;
	logic [`DL_ADDR_W-1:0]   dl_addr;
	logic [15:0]             dl_data;
	logic                    cpu_stb;
	logic                    cpu_we;
	logic                    cpu_ack;
	logic [`CART_ADDR_W-1:0] cpu_addr;
	logic [7:0]              cpu_wdata;
	logic [7:0]              cpu_rdata;
	logic                    wb_cyc;
	logic                    wb_stb;
	logic                    wb_we;
	logic                    wb_ack;
	logic [`MEM_ADDR_W-1:0]  wb_adr;
	logic [1:0]              wb_sel;
	logic [15:0]             wb_dat_o;
	logic [15:0]             wb_dat_i;

	int                    checks;
	int                    errors;
	int                    tests;
	int                    errors_at_start;
	logic [`DL_ADDR_W-1:0] q_addr[$];     // image words waiting for download
	logic [15:0]           q_data[$];

	cart_mapper uut (.*);

	wb_mem_model mem_model (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_sel   (wb_sel),
		.wb_dat_w (wb_dat_o),
		.wb_dat_r (wb_dat_i),
		.wb_ack   (wb_ack)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ------------------------------
	// helpers
	task automatic next_cycle();
		@(posedge clk_sys);
		#1; // drive and sample just after the edge
	endtask

	task automatic check(input logic [15:0] got, input logic [15:0] exp, input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED at %0t ns: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic give_up(input string what);
		$display("timeout: %s, no answer from the DUT", what);
		$display("Something failed");
		$finish;
	endtask

	// 16k rom bank b at offset 0 is memory bank {b, a13=0}
	function automatic logic [20:0] rom_word(input logic [6:0] b);
		return {1'b0, b, 13'd0};
	endfunction

	// 8k ram bank b sits at memory bank 256 + b
	function automatic logic [20:0] ram_word(input logic [1:0] b);
		return {1'b1, 6'd0, b, 12'd0};
	endfunction

	function automatic logic [15:0] tag(input logic [20:0] w);
		return {w[20:13], w[19:12]} ^ 16'h5AC3; // differs per 8k bank
	endfunction

	function automatic logic [7:0] lane_of(input logic [15:0] word, input logic odd);
		return odd ? word[15:8] : word[7:0];
	endfunction

	task automatic stage_word(input logic [`DL_ADDR_W-1:0] addr, input logic [15:0] data);
		q_addr.push_back(addr);
		q_data.push_back(data);
	endtask

	task automatic header_words(input logic [7:0] ctype, input logic [7:0] rom_sz,
			input logic [7:0] ram_sz);
		stage_word(`HDR_TYPE_ADDR, {ctype, 8'h00});
		stage_word(`HDR_SIZE_ADDR, {ram_sz, rom_sz});
	endtask

	task automatic place_tagged(input logic [20:0] w);
		stage_word({3'b000, w, 1'b0}, tag(w));
	endtask

	// streams the staged words and checks handshake and memory contents per word
	task automatic download_image();
		int n;
		dl_active = 1'b1;
		next_cycle();
		foreach (q_addr[i]) begin
			dl_wr   = 1'b1;
			dl_addr = q_addr[i];
			dl_data = q_data[i];
			next_cycle();
			dl_wr = 1'b0;
			check(dl_wait, 1'b1, "dl_wait raised after dl_wr");
			n = 0;
			while (dl_wait && n < TIMEOUT) begin
				next_cycle();
				n++;
			end
			if (dl_wait)
				give_up($sformatf("download word at %h", q_addr[i]));
			check(mem_model.peek(q_addr[i][21:1]), q_data[i],
				$sformatf("downloaded word at %h", q_addr[i]));
		end
		dl_active = 1'b0;
		q_addr.delete();
		q_data.delete();
		next_cycle();
		next_cycle(); // header decode is registered
	endtask

	task automatic cpu_access(input logic we, input logic [15:0] addr, input logic [7:0] wdata,
			output logic [7:0] rdata);
		int n;
		cpu_stb   = 1'b1;
		cpu_we    = we;
		cpu_addr  = addr;
		cpu_wdata = wdata;
		next_cycle();
		n = 1;
		while (!cpu_ack && n < TIMEOUT) begin
			next_cycle();
			n++;
		end
		if (!cpu_ack)
			give_up($sformatf("cpu access to %h", addr));
		rdata   = cpu_rdata; // valid with the ack
		cpu_stb = 1'b0;
		cpu_we  = 1'b0;
		next_cycle();
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		cpu_access(1'b1, addr, data, unused);
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [7:0] exp, input string msg);
		logic [7:0] r;
		cpu_access(1'b0, addr, 8'h00, r);
		check({8'h00, r}, {8'h00, exp}, msg);
	endtask

	task automatic expect_word(input logic [15:0] addr, input logic [20:0] w, input string msg);
		read_check(addr, lane_of(tag(w), addr[0]), msg);
	endtask

	task automatic begin_test();
		errors_at_start = errors;
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("%s: finished with %0d errors", name, errors - errors_at_start);
	endtask

	// ------------------------------
	// directed tests
	task automatic linear_rom_reads();
		begin_test();
		read_check(16'h0123, 8'h00, "no cart, 0123");
		read_check(16'h4567, 8'h00, "no cart, 4567");
		header_words(8'h00, 8'h00, 8'h00); // rom only
		stage_word(25'h0122, 16'h5AC3);
		stage_word(25'h4566, 16'h9E71);
		download_image();
		read_check(16'h0123, 8'h5A, "linear 0123");
		read_check(16'h0122, 8'hC3, "linear 0122");
		read_check(16'h4567, 8'h9E, "linear 4567");
		read_check(16'h4566, 8'h71, "linear 4566");
		read_check(16'hA000, 8'hFF, "no ram without mapper");
		end_test("linear rom");
	endtask

	task automatic mbc1_banking();
		begin_test();
		header_words(8'h01, 8'h02, 8'h03); // 8 rom banks, 4 ram banks
		place_tagged(rom_word(7'd0));
		place_tagged(rom_word(7'd1));
		place_tagged(rom_word(7'd5));
		place_tagged(ram_word(2'd0));
		place_tagged(ram_word(2'd1));
		download_image();
		expect_word(16'h0000, rom_word(7'd0), "mbc1 fixed bank");
		expect_word(16'h4001, rom_word(7'd1), "mbc1 bank after reset");
		cpu_write(16'h2000, 8'h00);
		expect_word(16'h4000, rom_word(7'd1), "mbc1 bank 0 becomes 1");
		cpu_write(16'h2000, 8'h05);
		expect_word(16'h4001, rom_word(7'd5), "mbc1 bank 5");
		cpu_write(16'h2000, 8'h0D);
		expect_word(16'h4000, rom_word(7'd5), "mbc1 bank 13 mirrors to 5");
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h01);        // ram field 1
		expect_word(16'h4000, rom_word(7'd5), "mbc1 mode 0, bank 0x2d masked");
		expect_word(16'hA000, ram_word(2'd0), "mbc1 mode 0 ram bank 0");
		cpu_write(16'h6000, 8'h01);
		expect_word(16'h4000, rom_word(7'd5), "mbc1 mode 1 rom bank");
		expect_word(16'hA000, ram_word(2'd1), "mbc1 mode 1 ram bank 1");
		end_test("mbc1 banking");
	endtask

	task automatic ram_enable_key();
		logic [15:0] t;
		begin_test();
		t = tag(ram_word(2'd0));
		header_words(8'h03, 8'h02, 8'h03);
		place_tagged(ram_word(2'd0));
		download_image();
		read_check(16'hA001, 8'hFF, "disabled ram read");
		cpu_write(16'hA001, 8'h77);
		check(mem_model.peek(ram_word(2'd0)), t, "disabled write left memory");
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'hA001, 8'h77);
		read_check(16'hA001, 8'h77, "enabled ram readback");
		check(mem_model.peek(ram_word(2'd0)), {8'h77, t[7:0]}, "write on high lane only");
		cpu_write(16'h0000, 8'h00);
		read_check(16'hA001, 8'hFF, "ram disabled again");
		end_test("ram enable");
	endtask

	task automatic mbc3_rtc_select();
		begin_test();
		header_words(8'h13, 8'h06, 8'h03); // mask 127
		place_tagged(rom_word(7'h45));
		place_tagged(ram_word(2'd2));
		download_image();
		cpu_write(16'h2000, 8'h45);
		expect_word(16'h4000, rom_word(7'h45), "mbc3 bank 45 low");
		expect_word(16'h4001, rom_word(7'h45), "mbc3 bank 45 high");
		cpu_write(16'h0000, 8'h0A);
		cpu_write(16'h4000, 8'h02);
		expect_word(16'hA000, ram_word(2'd2), "mbc3 ram bank 2");
		cpu_write(16'h4000, 8'h08);        // clock register select
		read_check(16'hA000, 8'hFF, "mbc3 rtc unmaps ram");
		end_test("mbc3 rtc select");
	endtask

	task automatic mbc5_bank_zero();
		begin_test();
		header_words(8'h19, 8'h04, 8'h00); // mask 31
		place_tagged(rom_word(7'd0));
		place_tagged(rom_word(7'd1));
		place_tagged(rom_word(7'd3));
		download_image();
		expect_word(16'h4000, rom_word(7'd1), "mbc5 bank after reset");
		cpu_write(16'h2000, 8'h00);
		expect_word(16'h4000, rom_word(7'd0), "mbc5 bank 0 accepted");
		cpu_write(16'h2000, 8'h03);
		expect_word(16'h4001, rom_word(7'd3), "mbc5 bank 3");
		end_test("mbc5 bank zero");
	endtask

	// ------------------------------
	initial begin
		reset     = 1'b1;
		dl_active = 1'b0;
		dl_wr     = 1'b0;
		dl_addr   = '0;
		dl_data   = '0;
		cpu_stb   = 1'b0;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		checks    = 0;
		errors    = 0;
		tests     = 0;
		repeat (10) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		next_cycle();
		linear_rom_reads();
		mbc1_banking();
		ram_enable_key();
		mbc3_rtc_select();
		mbc5_bank_zero();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* sim/wb_mem_model.sv */
`include "cart_settings.svh"

module wb_mem_model (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   wb_cyc,
	input  logic                   wb_stb,
	input  logic                   wb_we,
	input  logic [`MEM_ADDR_W-1:0] wb_adr,
	input  logic [1:0]             wb_sel,
	input  logic [15:0]            wb_dat_w,  // write data from the master
	output logic [15:0]            wb_dat_r,
	output logic                   wb_ack
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [15:0] mem [logic [20:0]]; // sparse, 2M words
	logic [7:0]  lfsr;
	logic [7:0]  lfsr_1;
	logic [7:0]  lfsr_2;
	logic [1:0]  wait_cnt;            // extra ack delay, 0 to 3
	logic        busy;

	// fibonacci, x^8 + x^6 + x^5 + x^4 + 1
	function automatic logic [7:0] lfsr_step(input logic [7:0] s);
		return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
	endfunction

	// unwritten words show a pattern of their full address
	function automatic logic [15:0] fill_word(input logic [20:0] a);
		return a[15:0] ^ {11'h2A5, a[20:16]};
	endfunction

	function automatic logic [15:0] peek(input logic [20:0] a);
		return mem.exists(a) ? mem[a] : fill_word(a);
	endfunction

	assign lfsr_1 = lfsr_step(lfsr);
	assign lfsr_2 = lfsr_step(lfsr_1); // one step per delay bit

	// ------------------------------
	always @(posedge clk_sys) begin
		logic [15:0] cur;
		if (reset) begin
			lfsr     <= 8'd72;
			busy     <= 1'b0;
			wait_cnt <= 2'd0;
			wb_ack   <= 1'b0;
		end else begin
			wb_ack <= 1'b0;
			if (wb_cyc && wb_stb && !wb_ack) begin
				if (!busy) begin
					busy     <= 1'b1;
					wait_cnt <= {lfsr_1[0], lfsr_2[0]};
					lfsr     <= lfsr_2;
				end else if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					busy   <= 1'b0;
					wb_ack <= 1'b1;
					cur = peek(wb_adr[20:0]);
					if (wb_we) begin
						if (wb_sel[0])
							cur[7:0] = wb_dat_w[7:0];   // even byte
						if (wb_sel[1])
							cur[15:8] = wb_dat_w[15:8]; // odd byte
						mem[wb_adr[20:0]] = cur;
					end
					wb_dat_r <= cur;
				end
			end
		end
	end

endmodule

/* hw/cart_mapper.sv */
`include "cart_settings.svh"

module cart_mapper (
	input  logic                    clk_sys,
	input  logic                    reset,
	// download
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  logic [`DL_ADDR_W-1:0]   dl_addr,
	input  logic [15:0]             dl_data,
	output logic                    dl_wait,
	// cpu
	input  logic                    cpu_stb,
	input  logic                    cpu_we,
	input  logic [`CART_ADDR_W-1:0] cpu_addr,
	input  logic [7:0]              cpu_wdata,
	output logic [7:0]              cpu_rdata,
	output logic                    cpu_ack,
	// wishbone master
	output logic                    wb_cyc,
	output logic                    wb_stb,
	output logic                    wb_we,
	output logic [`MEM_ADDR_W-1:0]  wb_adr,
	output logic [1:0]              wb_sel,
	output logic [15:0]             wb_dat_o,
	input  logic [15:0]             wb_dat_i,
	input  logic                    wb_ack
);

	logic [1:0]             family;
	logic [`ROM_BANK_W-1:0] rom_mask, rom_bank;
	logic [`RAM_BANK_W-1:0] ram_mask, ram_bank;
	logic                   rtc_mode, ram_enable, reg_wr;
	logic [`MEM_ADDR_W-1:0] mem_adr;
	logic [1:0]             mem_sel;
	logic                   is_ram_area, ram_access_ok;
	logic [7:0]             rd_byte;

	cart_header u_header (.*);  // header snoop, masks, family
	mbc_regs    u_regs   (.*);  // bank registers
	bank_map    u_map    (.*);  // cpu address to memory word
	cart_ctrl   u_ctrl   (.*);  // arbitration and bus sequencing

endmodule

/* hw/cart_ctrl.sv */
`include "cart_settings.svh"

module cart_ctrl (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,
	input  logic                    dl_wr,
	input  logic [`DL_ADDR_W-1:0]   dl_addr,
	input  logic [15:0]             dl_data,
	input  logic                    cpu_stb,
	input  logic                    cpu_we,
	input  logic [`CART_ADDR_W-1:0] cpu_addr,
	input  logic [7:0]              cpu_wdata,
	input  logic [`MEM_ADDR_W-1:0]  mem_adr,
	input  logic [1:0]              mem_sel,
	input  logic                    is_ram_area,
	input  logic                    ram_access_ok,
	input  logic [7:0]              rd_byte,
	input  logic [15:0]             wb_dat_i,
	input  logic                    wb_ack,
	output logic                    dl_wait,
	output logic                    cpu_ack,
	output logic [7:0]              cpu_rdata,
	output logic                    reg_wr,
	output logic                    wb_cyc,
	output logic                    wb_stb,
	output logic                    wb_we,
	output logic [`MEM_ADDR_W-1:0]  wb_adr,
	output logic [1:0]              wb_sel,
	output logic [15:0]             wb_dat_o
);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_BUS  = 2'd1; // one wishbone cycle outstanding
	localparam logic [1:0] ST_ACK  = 2'd2; // cpu_ack high

	logic [1:0]            state;
	logic                  cart_ready; // first image word landed
	logic                  dl_pend;    // word latched, bus not started yet
	logic                  bus_dl;     // bus cycle belongs to the download
	logic [`DL_ADDR_W-1:0] dl_addr_q;
	logic [15:0]           dl_data_q;
	cart_pkg::ctrl_byte_u  wr_byte;
	logic                  cpu_go, need_bus, start_dl, start_cpu, imm_ack, bus_done;

	assign wr_byte  = cpu_wdata;
	assign cpu_go   = (state == ST_IDLE) && !dl_pend && !dl_active && cpu_stb;
	// reads of rom, or enabled ram, go to memory; the rest is answered here
	assign need_bus = cart_ready && (is_ram_area ? ram_access_ok : !cpu_we);
	assign start_dl  = (state == ST_IDLE) && dl_pend; // download wins
	assign start_cpu = cpu_go && need_bus;
	assign imm_ack   = cpu_go && !need_bus;
	assign bus_done  = (state == ST_BUS) && wb_ack;
	assign reg_wr    = cpu_go && cpu_we && !cpu_addr[15];

	// ------------------------------
	// control state
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state      <= ST_IDLE;
			cart_ready <= 1'b0;
			dl_pend    <= 1'b0;
			dl_wait    <= 1'b0;
			bus_dl     <= 1'b0;
			cpu_ack    <= 1'b0;
			wb_cyc     <= 1'b0;
			wb_stb     <= 1'b0;
		end else begin
			cpu_ack <= 1'b0; // pulse
			if (dl_wr) begin
				dl_pend <= 1'b1;
				dl_wait <= 1'b1; // held until the word is acked
			end
			case (state)
				ST_IDLE: begin
					if (start_dl || start_cpu) begin
						dl_pend <= 1'b0;
						bus_dl  <= start_dl;
						wb_cyc  <= 1'b1;
						wb_stb  <= 1'b1;
						state   <= ST_BUS;
					end else if (imm_ack) begin
						cpu_ack <= 1'b1;
						state   <= ST_ACK;
					end
				end
				ST_BUS: if (wb_ack) begin
					wb_cyc <= 1'b0;
					wb_stb <= 1'b0;
					if (bus_dl) begin
						dl_wait    <= 1'b0;
						cart_ready <= 1'b1;
						state      <= ST_IDLE;
					end else begin
						cpu_ack <= 1'b1;
						state   <= ST_ACK;
					end
				end
				ST_ACK: state <= ST_IDLE; // cpu drops stb now
				default: state <= ST_IDLE;
			endcase
		end
	end

	// ------------------------------
	// bus payload and read data
	always_ff @(posedge clk_sys) begin
		if (dl_wr) begin
			dl_addr_q <= dl_addr;
			dl_data_q <= dl_data;
		end
		if (start_dl) begin
			wb_adr   <= dl_addr_q[`DL_ADDR_W-1:1];
			wb_sel   <= 2'b11;        // whole word
			wb_we    <= 1'b1;
			wb_dat_o <= dl_data_q;
		end else if (start_cpu) begin
			wb_adr   <= mem_adr;
			wb_sel   <= mem_sel;
			wb_we    <= cpu_we;
			wb_dat_o <= {wr_byte, wr_byte}; // byte in both lanes, sel picks
		end
		if (imm_ack)
			cpu_rdata <= cart_ready ? 8'hFF : 8'h00; // open bus vs no cart
		else if (bus_done && !bus_dl)
			cpu_rdata <= rd_byte;
	end

	a_stb_cyc: assert property (@(posedge clk_sys) disable iff (reset)
		wb_stb |-> wb_cyc);
	a_ack_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_ack |=> !cpu_ack);
	a_dl_hold: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr |-> !dl_wait);
	// lane picked by the mapper agrees with the latched byte select
	a_rd_lane: assert property (@(posedge clk_sys) disable iff (reset)
		(bus_done && !bus_dl && !wb_we)
			|-> rd_byte == (wb_sel[1] ? wb_dat_i[15:8] : wb_dat_i[7:0]));

endmodule

/* hw/bank_map.sv */
`include "cart_settings.svh"

module bank_map (
	input  logic [`CART_ADDR_W-1:0] cpu_addr,
	input  logic [1:0]              family,
	input  logic [`ROM_BANK_W-1:0]  rom_mask,
	input  logic [`RAM_BANK_W-1:0]  ram_mask,
	input  logic [`ROM_BANK_W-1:0]  rom_bank,
	input  logic [`RAM_BANK_W-1:0]  ram_bank,
	input  logic                    rtc_mode,
	input  logic                    ram_enable,
	input  logic [15:0]             wb_dat_i,
	output logic [`MEM_ADDR_W-1:0]  mem_adr,
	output logic [1:0]              mem_sel,
	output logic                    is_ram_area,
	output logic                    ram_access_ok,
	output logic [7:0]              rd_byte
);

	localparam int PAD_W = `MEM_ADDR_W - `BANK_W - 12; // unused top of the word address

	logic [`ROM_BANK_W-1:0] rom_masked;
	logic [`RAM_BANK_W-1:0] ram_masked;
	logic [`BANK_W-1:0]     bank;

	// mirror banks that lie past the end of the image
	assign rom_masked = rom_bank & rom_mask;
	assign ram_masked = ram_bank & ram_mask;

	// ------------------------------
	// bank number, 8k granules
	always_comb begin
		if (family == `FAM_NONE) begin
			bank = {{(`BANK_W-2){1'b0}}, cpu_addr[14:13]}; // plain 32k rom
		end else begin
			case (cpu_addr[15:13])
				3'b000, 3'b001: bank = {{(`BANK_W-1){1'b0}}, cpu_addr[13]};  // fixed bank 0
				3'b010, 3'b011: bank = {1'b0, rom_masked, cpu_addr[13]};    // switchable 16k
				3'b101: bank = {1'b1, {(`BANK_W-1-`RAM_BANK_W){1'b0}}, ram_masked}; // ram at 256
				default: bank = '0;
			endcase
		end
	end

	assign mem_adr = {{PAD_W{1'b0}}, bank, cpu_addr[12:1]};
	assign mem_sel = {cpu_addr[0], ~cpu_addr[0]};   // odd byte on the high lane

	assign is_ram_area   = (cpu_addr[15:13] == 3'b101);
	assign ram_access_ok = is_ram_area && ram_enable && !rtc_mode
		&& (family != `FAM_NONE); // rom-only carts have no ram here

	assign rd_byte = cpu_addr[0] ? wb_dat_i[15:8] : wb_dat_i[7:0];

endmodule

/* hw/mbc_regs.sv */
`include "cart_settings.svh"

module mbc_regs (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    dl_active,
	input  logic                    reg_wr,
	input  logic [`CART_ADDR_W-1:0] cpu_addr,
	input  logic [7:0]              cpu_wdata,
	input  logic [1:0]              family,
	output logic [`ROM_BANK_W-1:0]  rom_bank,
	output logic [`RAM_BANK_W-1:0]  ram_bank,
	output logic                    rtc_mode,
	output logic                    ram_enable
);

	cart_pkg::ctrl_byte_u wbyte;
	logic [2:0]             region;   // 8k window of the write
	logic [4:0]             mbc1_lo;  // mbc1 5 bit rom bank
	logic [`RAM_BANK_W-1:0] mbc1_ram; // ram bank or rom bits 6:5
	logic                   mbc1_mode;
	logic [`ROM_BANK_W-1:0] mbc3_rom;
	logic [`RAM_BANK_W-1:0] mbc3_ram;
	logic                   mbc3_rtc;
	logic [`ROM_BANK_W-1:0] mbc5_rom;
	logic [`RAM_BANK_W-1:0] mbc5_ram;

	assign wbyte  = cpu_wdata;
	assign region = cpu_addr[15:13];

	// ------------------------------
	// register writes, cleared for the whole download
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			ram_enable <= 1'b0;
			mbc1_lo    <= 5'd1;
			mbc1_ram   <= '0;
			mbc1_mode  <= 1'b0;
			mbc3_rom   <= 7'd1;
			mbc3_ram   <= '0;
			mbc3_rtc   <= 1'b0;
			mbc5_rom   <= 7'd1;
			mbc5_ram   <= '0;
		end else if (reg_wr) begin
			case (region)
				3'b000: ram_enable <= (cpu_wdata[3:0] == `RAM_ENABLE_KEY); // any other value locks
				3'b001: begin
					if (family == `FAM_MBC1) // bank 0 not selectable
						mbc1_lo <= (wbyte.rom.bank_lo == 5'd0) ? 5'd1 : wbyte.rom.bank_lo;
					if (family == `FAM_MBC3)
						mbc3_rom <= (wbyte.rom.bank_lo == 5'd0) ? 7'd1
							: {wbyte.rom.bank_hi, wbyte.rom.bank_lo};
					if (family == `FAM_MBC5)
						mbc5_rom <= {wbyte.rom.bank_hi, wbyte.rom.bank_lo}; // 0 allowed
				end
				3'b010: begin
					if (family == `FAM_MBC1)
						mbc1_ram <= wbyte.ram.ram_bank;
					if (family == `FAM_MBC3) begin
						mbc3_rtc <= wbyte.ram.rtc_select; // clock regs replace ram
						if (!wbyte.ram.rtc_select)
							mbc3_ram <= wbyte.ram.ram_bank;
					end
					if (family == `FAM_MBC5)
						mbc5_ram <= wbyte.ram.ram_bank;
				end
				3'b011: if (family == `FAM_MBC1) mbc1_mode <= cpu_wdata[0];
				default: ;
			endcase
		end
	end

	// ------------------------------
	// active family drives the bank outputs
	always_comb begin
		rom_bank = 7'd1;
		ram_bank = '0;
		rtc_mode = 1'b0;
		case (family)
			`FAM_MBC1: begin
				if (mbc1_mode) begin // 4/32 mode, ram field banks ram
					rom_bank = {2'b00, mbc1_lo};
					ram_bank = mbc1_ram;
				end else begin       // 16/8 mode, ram field is rom a20:a19
					rom_bank = {mbc1_ram, mbc1_lo};
				end
			end
			`FAM_MBC3: begin
				rom_bank = mbc3_rom;
				ram_bank = mbc3_ram;
				rtc_mode = mbc3_rtc;
			end
			`FAM_MBC5: begin
				rom_bank = mbc5_rom;
				ram_bank = mbc5_ram;
			end
			default: ;
		endcase
	end

	// the controller only pulses reg_wr for the mapper window
	a_reg_window: assert property (@(posedge clk_sys) disable iff (reset)
		reg_wr |-> !cpu_addr[15]);

endmodule

/* hw/cart_header.sv */
`include "cart_settings.svh"

module cart_header (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  logic                   dl_wr,
	input  logic [`DL_ADDR_W-1:0]  dl_addr,
	input  logic [15:0]            dl_data,
	output logic [1:0]             family,
	output logic [`ROM_BANK_W-1:0] rom_mask,
	output logic [`RAM_BANK_W-1:0] ram_mask
);

	logic [7:0] type_byte; // header 0x147
	logic [7:0] rom_size;  // header 0x148
	logic [7:0] ram_size;  // header 0x149

	// ------------------------------
	// snoop the image as it streams past
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			type_byte <= 8'h00;
			rom_size  <= 8'h00;
			ram_size  <= 8'h00;
		end else if (dl_active && dl_wr) begin
			if (dl_addr == `HDR_TYPE_ADDR)
				type_byte <= dl_data[15:8]; // odd byte, high lane
			if (dl_addr == `HDR_SIZE_ADDR) begin
				rom_size <= dl_data[7:0];
				ram_size <= dl_data[15:8];
			end
		end
	end

	// decoded view, one cycle behind the raw bytes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			family   <= `FAM_NONE;
			rom_mask <= cart_pkg::rom_mask_of(8'h00); // 2 banks
			ram_mask <= cart_pkg::ram_mask_of(8'h00);
		end else begin
			family   <= cart_pkg::family_of(type_byte);
			rom_mask <= cart_pkg::rom_mask_of(rom_size);
			ram_mask <= cart_pkg::ram_mask_of(ram_size);
		end
	end

endmodule

/* hw/cart_pkg.sv */
`include "cart_settings.svh"

package cart_pkg;

	// one byte written by the cpu into a mapper register
	typedef union packed {
		struct packed {
			logic       spare;    // bit 7, ignored
			logic [1:0] bank_hi;  // upper bank bits, mbc3 and mbc5 only
			logic [4:0] bank_lo;  // mbc1 bank field
		} rom;
		struct packed {
			logic [3:0] high;
			logic       rtc_select; // mbc3 clock register select
			logic       spare;
			logic [1:0] ram_bank;
		} ram;
	} ctrl_byte_u;

	// rom size byte to bank mask, gives mirroring on small images
	function automatic logic [`ROM_BANK_W-1:0] rom_mask_of(input logic [7:0] size);
		case (size)
			8'h00: return 7'h01; // 32k, 2 banks
			8'h01: return 7'h03;
			8'h02: return 7'h07;
			8'h03: return 7'h0F;
			8'h04: return 7'h1F;
			8'h05: return 7'h3F;
			8'h06: return 7'h7F; // 2M
			8'h52: return 7'h47; // 72 banks
			8'h53: return 7'h4F; // 80 banks
			default: return 7'h5F; // 96 banks
		endcase
	endfunction

	function automatic logic [`RAM_BANK_W-1:0] ram_mask_of(input logic [7:0] size);
		return (size == 8'h01 || size == 8'h02) ? 2'b00 : 2'b11; // single 2k/8k bank
	endfunction

	function automatic logic [1:0] family_of(input logic [7:0] cart_type);
		if (cart_type inside {[8'h01:8'h03]}) return `FAM_MBC1;
		if (cart_type inside {[8'h0F:8'h13]}) return `FAM_MBC3;
		if (cart_type inside {[8'h19:8'h1E]}) return `FAM_MBC5;
		return `FAM_NONE; // rom only, or a mapper not handled here
	endfunction

endpackage

/* hw/cart_settings.svh */
`ifndef CART_SETTINGS_SVH
`define CART_SETTINGS_SVH

// ------------------------------
// bus and address widths
`define CART_ADDR_W     16      // cpu side, one word
`define MEM_ADDR_W      24      // memory word address
`define DL_ADDR_W       25      // download byte address
`define BANK_W          9       // mem address bits 20:12
`define ROM_BANK_W      7
`define RAM_BANK_W      2

// ------------------------------
// cartridge header, as download byte addresses of the 16 bit words
`define HDR_TYPE_ADDR   25'h146 // type byte in the high lane
`define HDR_SIZE_ADDR   25'h148 // rom size low lane, ram size high lane

`define RAM_ENABLE_KEY  4'hA    // low nibble written to 0000-1fff

// mapper family codes
`define FAM_NONE        2'd0    // 32k linear
`define FAM_MBC1        2'd1
`define FAM_MBC3        2'd2
`define FAM_MBC5        2'd3

`endif
